// ==== vlog.f ====
+incdir+hw
hw/rvIsaPkg.sv
hw/rvExecPkg.sv
hw/instrStencil.sv
hw/aluUnit.sv
hw/branchUnit.sv
hw/writebackSelect.sv
hw/execCore.sv
test/execCoreTb.sv

// ==== Makefile ====
TOP := execCoreTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir

// ==== test/execCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module execCoreTb;
    import rvIsaPkg::*;
    import rvExecPkg::*;

    typedef struct packed {
        logic [31:0] retireCycle;
        logic        illegal;
        logic        writeEn;
        RegAddr      rd;
        logic        checkData; // Low for branches
        Word         data;
        logic        redirect;
        Word         redirectPc;
        MemReq       memReq;
    } Expected;

    logic        clk, rstN, issueValid;
    Instruction  instr;
    Word         pc, rs1Val, rs2Val, redirectPc;
    logic        wbValid, redirectValid, illegal;
    Writeback    wb;
    MemReq       memReq;

    logic [31:0] lcgState = 32'heb18c6f3;
    logic [31:0] cycle = '0; // Rising edges seen so far
    Expected     pending[$];
    Expected     expHead;
    logic        expPresent = 1'b0;

    execCore UUT (
        .clk           (clk),
        .rstN          (rstN),
        .issueValid    (issueValid),
        .instr         (instr),
        .pc            (pc),
        .rs1Val        (rs1Val),
        .rs2Val        (rs2Val),
        .wbValid       (wbValid),
        .wb            (wb),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .memReq        (memReq),
        .illegal       (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Integer rule on funct3 with alt taken from instruction bit 30
    function automatic Word aluCalc(logic [2:0] f3, logic alt, logic isReg, Word x, Word y);
        case (f3)
            3'd0:    return (alt && isReg) ? x - y : x + y; // SUB only for register form
            3'd1:    return x << y[4:0];
            3'd2:    return {31'b0, $signed(x) < $signed(y)};
            3'd3:    return {31'b0, x < y};
            3'd4:    return x ^ y;
            3'd5:    return alt ? Word'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic Expected predict(Instruction ins, Word pcVal, Word a, Word b,
                                        logic [31:0] retire);
        Expected     e;
        logic [31:0] raw;
        logic [4:0]  op;
        logic [2:0]  f3;
        Word         iImm, sImm, bImm, uImm, jImm;
        logic        cond;
        raw  = ins;
        op   = raw[6:2];
        f3   = raw[14:12];
        iImm = {{(`XLEN-12){raw[31]}}, raw[31:20]};
        sImm = {{(`XLEN-12){raw[31]}}, raw[31:25], raw[11:7]};
        bImm = {{(`XLEN-12){raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
        uImm = {raw[31:12], 12'b0};
        jImm = {{(`XLEN-20){raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
        e = '0;
        e.retireCycle = retire;
        e.rd = raw[11:7];
        e.illegal = raw[1:0] != 2'b11
            || !(op inside {LOAD, STORE, OP_IMM, OP, LUI, AUIPC, BRANCH, JAL, JALR})
            || (op == STORE && f3[2]) || (op == LOAD && f3[1:0] == 2'b11)
            || (op == BRANCH && f3[2:1] == 2'b01);
        if (e.illegal) return e; // Only the trap flag leaves the core
        e.writeEn = op inside {OP, OP_IMM, LUI, AUIPC, JAL, JALR} && e.rd != 5'd0;
        e.checkData = op != BRANCH;
        case (op)
            OP:      e.data = aluCalc(f3, raw[30], 1'b1, a, b);
            OP_IMM:  e.data = aluCalc(f3, raw[30], 1'b0, a, iImm);
            LUI:     e.data = uImm;
            AUIPC:   e.data = pcVal + uImm;
            LOAD:    e.data = a + iImm; // Effective address
            STORE:   e.data = a + sImm;
            default: e.data = pcVal + 32'd4; // Link value
        endcase
        case (f3)
            3'd0:    cond = a == b;
            3'd1:    cond = a != b;
            3'd4:    cond = $signed(a) < $signed(b);
            3'd5:    cond = $signed(a) >= $signed(b);
            3'd6:    cond = a < b;
            default: cond = a >= b;
        endcase
        e.redirect = op == JAL || op == JALR || (op == BRANCH && cond);
        e.redirectPc = (op == JALR) ? ((a + iImm) & ~32'd1) : pcVal + ((op == JAL) ? jImm : bImm);
        if (op == LOAD || op == STORE) begin
            e.memReq.isLoad   = op == LOAD;
            e.memReq.isStore  = op == STORE;
            e.memReq.width    = MemWidth'(f3[1:0]);
            e.memReq.isSigned = op == LOAD && !f3[2];
        end
        return e;
    endfunction

    // Weighted opcode mix whose last two slots are trap encodings
    function automatic Instruction randomInstr();
        logic [31:0] raw;
        logic [31:0] sel;
        raw = nextRand();
        sel = nextRand();
        raw[1:0] = 2'b11;
        case (sel[31:28])
            4'd0, 4'd1, 4'd2: raw[6:2] = OP;
            4'd3, 4'd4, 4'd5: raw[6:2] = OP_IMM;
            4'd6:             raw[6:2] = LUI;
            4'd7:             raw[6:2] = AUIPC;
            4'd8, 4'd9:       raw[6:2] = BRANCH;
            4'd10:            raw[6:2] = JAL;
            4'd11:            raw[6:2] = JALR;
            4'd12:            raw[6:2] = LOAD;
            4'd13:            raw[6:2] = STORE;
            4'd14:            raw[6:2] = sel[27] ? SYSTEM : 5'b00011; // Unknown opcode
            default:          raw[1:0] = (sel[26:25] == 2'b11) ? 2'b00 : sel[26:25];
        endcase
        return raw;
    endfunction

    // Head of the in-flight list lines up with its retire edge
    always @(negedge clk) begin
        while (pending.size() != 0 && pending[0].retireCycle < cycle) begin
            void'(pending.pop_front());
        end
        expPresent = pending.size() != 0 && pending[0].retireCycle == cycle;
        if (expPresent) expHead = pending[0];
    end

    idleQuiet: assert property (@(posedge clk) disable iff (!rstN)
        !expPresent |-> !wbValid && !redirectValid && !wb.writeEn && !illegal && memReq == '0)
        else abortRun($sformatf("Mismatch at %0t: outputs active with nothing retiring", $time));

    retireOnTime: assert property (@(posedge clk) disable iff (!rstN) expPresent |-> wbValid)
        else abortRun($sformatf("Mismatch at %0t: wbValid low two cycles after issue", $time));

    trapFlag: assert property (@(posedge clk) disable iff (!rstN)
        expPresent |-> illegal == expHead.illegal)
        else abortRun($sformatf("Mismatch at %0t: illegal %b expected %b",
                                $time, $sampled(illegal), expHead.illegal));

    writePort: assert property (@(posedge clk) disable iff (!rstN)
        expPresent |-> wb.writeEn == expHead.writeEn
            && (!expHead.writeEn || wb.rd == expHead.rd)
            && (!expHead.checkData || wb.data == expHead.data))
        else abortRun($sformatf("Mismatch at %0t: wb rd %0d data %h en %b, expected %0d %h %b",
                                $time, $sampled(wb.rd), $sampled(wb.data), $sampled(wb.writeEn),
                                expHead.rd, expHead.data, expHead.writeEn));

    redirectPort: assert property (@(posedge clk) disable iff (!rstN)
        expPresent |-> redirectValid == expHead.redirect
            && (!expHead.redirect || redirectPc == expHead.redirectPc))
        else abortRun($sformatf("Mismatch at %0t: redirect %b pc %h, expected %b %h",
                                $time, $sampled(redirectValid), $sampled(redirectPc),
                                expHead.redirect, expHead.redirectPc));

    memPort: assert property (@(posedge clk) disable iff (!rstN)
        expPresent |-> memReq == expHead.memReq)
        else abortRun($sformatf("Mismatch at %0t: memReq %b expected %b",
                                $time, $sampled(memReq), expHead.memReq));

    initial begin
        logic [31:0] r;
        int          issued;
        int          waited;
        issueValid = 1'b0;
        instr      = '0;
        pc         = `RESET_PC;
        rs1Val     = '0;
        rs2Val     = '0;
        rstN       = 1'b0;
        repeat (4) @(posedge clk);
        #1 rstN = 1'b1;
        repeat (3) @(posedge clk); // Idle outputs after reset
        issued = 0;
        while (issued < 600) begin
            @(posedge clk);
            #1;
            r          = nextRand();
            issueValid = r[31:29] != 3'b000; // Occasional bubble
            instr      = randomInstr();
            pc         = `RESET_PC + (nextRand() & 32'h000f_fffc);
            rs1Val     = nextRand();
            rs2Val     = (r[28:27] == 2'b00) ? rs1Val : nextRand(); // Equal operands now and then
            if (issueValid) begin
                pending.push_back(predict(instr, pc, rs1Val, rs2Val, cycle + 32'd2));
                issued++;
            end
        end
        @(posedge clk);
        #1 issueValid = 1'b0;
        waited = 0;
        while (pending.size() != 0 && waited < 10) begin
            @(posedge clk);
            waited++;
        end
        if (pending.size() != 0) begin
            abortRun("Timeout: instructions still in flight after the pipeline should drain");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== hw/execCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module execCore (
    input  wire                       clk,
    input  wire                       rstN,
    input  wire                       issueValid,
    input  wire rvIsaPkg::Instruction instr,
    input  wire rvIsaPkg::Word        pc,
    input  wire rvIsaPkg::Word        rs1Val,
    input  wire rvIsaPkg::Word        rs2Val,
    output logic                      wbValid,
    output rvExecPkg::Writeback       wb,
    output logic                      redirectValid,
    output rvIsaPkg::Word             redirectPc,
    output rvExecPkg::MemReq          memReq,
    output logic                      illegal
);
    import rvExecPkg::*;

    DecodedInstr dec;
    AluResult    aluRes;
    BranchResult brRes;

    instrStencil decoder (
        .instr (instr),
        .dec   (dec)
    );

    aluUnit alu (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issueValid),
        .dec        (dec),
        .pc         (pc),
        .rs1Val     (rs1Val),
        .rs2Val     (rs2Val),
        .aluRes     (aluRes)
    );

    branchUnit branch (
        .clk        (clk),
        .rstN       (rstN),
        .issueValid (issueValid),
        .dec        (dec),
        .pc         (pc),
        .rs1Val     (rs1Val),
        .rs2Val     (rs2Val),
        .brRes      (brRes)
    );

    // Stage 2 retires two cycles after issue
    writebackSelect retire (
        .clk           (clk),
        .rstN          (rstN),
        .aluRes        (aluRes),
        .brRes         (brRes),
        .wbValid       (wbValid),
        .wb            (wb),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .memReq        (memReq),
        .illegal       (illegal)
    );

endmodule

`default_nettype wire

// ==== hw/writebackSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module writebackSelect (
    input  wire                         clk,
    input  wire                         rstN,
    input  wire rvExecPkg::AluResult    aluRes,
    input  wire rvExecPkg::BranchResult brRes,
    output logic                        wbValid,
    output rvExecPkg::Writeback         wb,
    output logic                        redirectValid,
    output rvIsaPkg::Word               redirectPc,
    output rvExecPkg::MemReq            memReq,
    output logic                        illegal
);

    logic writeEn;

    // x0 is hardwired, so it never takes a write
    assign writeEn = aluRes.valid && aluRes.writesRd && aluRes.rd != '0;

    always_ff @(posedge clk) begin
        wb.rd      <= aluRes.rd;
        wb.data    <= brRes.isJump ? brRes.link : aluRes.value; // Link for JAL/JALR
        redirectPc <= brRes.target;
        if (!rstN) begin
            wbValid       <= 1'b0;
            wb.writeEn    <= 1'b0;
            redirectValid <= 1'b0;
            illegal       <= 1'b0;
            memReq        <= '0;
        end else begin
            wbValid       <= aluRes.valid;
            wb.writeEn    <= writeEn;
            redirectValid <= brRes.taken;
            illegal       <= aluRes.valid && aluRes.illegal;
            memReq        <= aluRes.valid ? aluRes.memReq : '0;
        end
    end

    // Both stage-1 units see the same issue strobe
    stagesInLockstep: assert property (@(posedge clk) disable iff (!rstN)
        aluRes.valid == brRes.valid);

    // A redirect always retires together with its writeback slot
    redirectWithRetire: assert property (@(posedge clk) disable iff (!rstN)
        redirectValid |-> wbValid && !illegal);

endmodule

`default_nettype wire

// ==== hw/branchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module branchUnit (
    input  wire                         clk,
    input  wire                         rstN,
    input  wire                         issueValid,
    input  wire rvExecPkg::DecodedInstr dec,
    input  wire rvIsaPkg::Word          pc,
    input  wire rvIsaPkg::Word          rs1Val,
    input  wire rvIsaPkg::Word          rs2Val,
    output rvExecPkg::BranchResult      brRes
);
    import rvIsaPkg::*;

    logic condTrue, taken, isJump;
    Word  target, link, jalrSum;

    always_comb begin
        case (BranchFunct3'(dec.funct3))
            BEQ:     condTrue = rs1Val == rs2Val;
            BNE:     condTrue = rs1Val != rs2Val;
            BLT:     condTrue = $signed(rs1Val) < $signed(rs2Val);
            BGE:     condTrue = $signed(rs1Val) >= $signed(rs2Val);
            BLTU:    condTrue = rs1Val < rs2Val;
            BGEU:    condTrue = rs1Val >= rs2Val;
            default: condTrue = 1'b0; // Encodings 2 and 3
        endcase
    end

    assign isJump  = dec.isJal || dec.isJalr;
    assign jalrSum = rs1Val + dec.imm;
    assign target  = dec.isJalr ? {jalrSum[`XLEN-1:1], 1'b0} : pc + dec.imm;
    assign link    = pc + Word'(4);

    // Trapping instructions never redirect
    assign taken = !dec.illegal && ((dec.isBranch && condTrue) || isJump);

    always_ff @(posedge clk) begin
        brRes.isJump <= isJump;
        brRes.target <= target;
        brRes.link   <= link;
        if (!rstN) begin
            brRes.valid <= 1'b0;
            brRes.taken <= 1'b0;
        end else begin
            brRes.valid <= issueValid;
            brRes.taken <= issueValid && taken;
        end
    end

    takenNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
        brRes.taken |-> brRes.valid);

endmodule

`default_nettype wire

// ==== hw/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  wire                         clk,
    input  wire                         rstN,
    input  wire                         issueValid,
    input  wire rvExecPkg::DecodedInstr dec,
    input  wire rvIsaPkg::Word          pc,
    input  wire rvIsaPkg::Word          rs1Val,
    input  wire rvIsaPkg::Word          rs2Val,
    output rvExecPkg::AluResult         aluRes
);
    import rvIsaPkg::*;
    import rvExecPkg::*;

    Word        opA, opB, value;
    logic [4:0] shamt;

    always_comb begin
        if (dec.useUpper) begin
            opA = (dec.opCode == AUIPC) ? pc : '0; // LUI adds to zero
        end else begin
            opA = rs1Val;
        end
    end

    assign opB   = dec.useImm ? dec.imm : rs2Val;
    assign shamt = opB[4:0];

    always_comb begin
        case (dec.aluCtrl)
            rvExecPkg::ADD:  value = opA + opB; // Also load/store address
            rvExecPkg::SUB:  value = opA - opB;
            rvExecPkg::SLL:  value = opA << shamt;
            rvExecPkg::SLT:  value = Word'($signed(opA) < $signed(opB));
            rvExecPkg::SLTU: value = Word'(opA < opB);
            rvExecPkg::XOR:  value = opA ^ opB;
            rvExecPkg::SRL:  value = opA >> shamt;
            rvExecPkg::SRA:  value = Word'($signed(opA) >>> shamt);
            rvExecPkg::OR:   value = opA | opB;
            rvExecPkg::AND:  value = opA & opB;
            default:         value = opA + opB;
        endcase
    end

    always_ff @(posedge clk) begin
        aluRes.rd     <= dec.rd;
        aluRes.value  <= value;
        aluRes.memReq <= dec.memReq;
        if (!rstN) begin
            aluRes.valid    <= 1'b0;
            aluRes.writesRd <= 1'b0;
            aluRes.illegal  <= 1'b0;
        end else begin
            aluRes.valid    <= issueValid;
            aluRes.writesRd <= issueValid && dec.writesRd && !dec.illegal;
            aluRes.illegal  <= issueValid && dec.illegal;
        end
    end

    // A trapping instruction must never reach the register file
    noWriteOnIllegal: assert property (@(posedge clk) disable iff (!rstN)
        !(aluRes.writesRd && aluRes.illegal));

endmodule

`default_nettype wire

// ==== hw/instrStencil.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_params.svh"

module instrStencil (
    input  wire rvIsaPkg::Instruction instr,
    output rvExecPkg::DecodedInstr    dec
);
    import rvIsaPkg::*;
    import rvExecPkg::*;

    Word      iImm, sImm, bImm, uImm, jImm, imm;
    AluFunct3 aluF3;
    AluCtrl   aluCtrl;
    MemReq    memReq;
    logic     isLoad, isStore, isOp, isOpImm, isBranch, isUpper;
    logic     knownOp, illegal;

    assign isLoad   = instr.opCode == LOAD;
    assign isStore  = instr.opCode == STORE;
    assign isOp     = instr.opCode == OP;
    assign isOpImm  = instr.opCode == OP_IMM;
    assign isBranch = instr.opCode == BRANCH;
    assign isUpper  = instr.opCode == LUI || instr.opCode == AUIPC;
    assign aluF3    = AluFunct3'(instr.funct3);

    // Immediates per format, all sign-extended from bit 31
    assign iImm = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign sImm = {{(`XLEN-12){instr[31]}}, instr.funct7, instr.rd};
    assign bImm = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign uImm = {instr[31:12], 12'b0};
    assign jImm = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (instr.opCode)
            OP_IMM, JALR: imm = iImm;
            LOAD:         imm = iImm; // Base offset
            STORE:        imm = sImm;
            BRANCH:       imm = bImm;
            LUI, AUIPC:   imm = uImm;
            JAL:          imm = jImm;
            default:      imm = '0; // OP has no immediate
        endcase
    end

    always_comb begin
        case (instr.opCode)
            LOAD, STORE, OP_IMM, OP, LUI, AUIPC, BRANCH, JAL, JALR: knownOp = 1'b1;
            default: knownOp = 1'b0; // SYSTEM lands here and traps
        endcase
    end

    // Loads, stores and upper immediates fall through as ADD
    always_comb begin
        aluCtrl = ADD;
        if (isOp || isOpImm) begin
            case (aluF3)
                ADD_SUB:        aluCtrl = (isOp && instr.funct7[5]) ? SUB : ADD;
                rvIsaPkg::SLL:  aluCtrl = rvExecPkg::SLL;
                rvIsaPkg::SLT:  aluCtrl = rvExecPkg::SLT;
                rvIsaPkg::SLTU: aluCtrl = rvExecPkg::SLTU;
                rvIsaPkg::XOR:  aluCtrl = rvExecPkg::XOR;
                SRLA:           aluCtrl = instr.funct7[5] ? SRA : SRL;
                rvIsaPkg::OR:   aluCtrl = rvExecPkg::OR;
                rvIsaPkg::AND:  aluCtrl = rvExecPkg::AND;
                default:        aluCtrl = ADD;
            endcase
        end
    end

    assign illegal = instr.lowBits != 2'b11 || !knownOp
                  || (isStore && instr.funct3[2])
                  || (isLoad && MemWidth'(instr.funct3[1:0]) == ERRVAL)
                  || (isBranch && instr.funct3[2:1] == 2'b01); // funct3 2 and 3

    always_comb begin
        memReq = '0;
        if ((isLoad || isStore) && !illegal) begin
            memReq.isLoad   = isLoad;
            memReq.isStore  = isStore;
            memReq.width    = MemWidth'(instr.funct3[1:0]);
            memReq.isSigned = isLoad && !instr.funct3[2]; // LBU and LHU clear it
        end
    end

    always_comb begin
        dec.opCode   = instr.opCode;
        dec.rd       = instr.rd;
        dec.funct3   = instr.funct3;
        dec.aluCtrl  = aluCtrl;
        dec.useImm   = isOpImm || isLoad || isStore || isUpper;
        dec.useUpper = isUpper;
        dec.imm      = imm;
        dec.writesRd = isOp || isOpImm || isUpper || instr.opCode == JAL
                    || instr.opCode == JALR;
        dec.isBranch = isBranch;
        dec.isJal    = instr.opCode == JAL;
        dec.isJalr   = instr.opCode == JALR;
        dec.memReq   = memReq;
        dec.illegal  = illegal;
    end

endmodule

`default_nettype wire

// ==== hw/rvExecPkg.sv ====
`default_nettype none

package rvExecPkg;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } AluCtrl;

    // Access descriptor for the external load-store unit
    typedef struct packed {
        logic             isLoad;
        logic             isStore;
        rvIsaPkg::MemWidth width;
        logic             isSigned; // Sign-extend loaded data
    } MemReq;

    typedef struct packed {
        rvIsaPkg::OpCode  opCode;
        rvIsaPkg::RegAddr rd;
        logic [2:0]       funct3;
        AluCtrl           aluCtrl;
        logic             useImm;   // Operand B from imm
        logic             useUpper; // Operand A is zero or pc
        rvIsaPkg::Word    imm;
        logic             writesRd;
        logic             isBranch;
        logic             isJal;
        logic             isJalr;
        MemReq            memReq;
        logic             illegal;
    } DecodedInstr;

    typedef struct packed {
        logic             valid;
        rvIsaPkg::RegAddr rd;
        logic             writesRd;
        rvIsaPkg::Word    value; // Result or effective address
        MemReq            memReq;
        logic             illegal;
    } AluResult;

    typedef struct packed {
        logic          valid;
        logic          taken;
        logic          isJump;
        rvIsaPkg::Word target;
        rvIsaPkg::Word link;
    } BranchResult;

    typedef struct packed {
        rvIsaPkg::RegAddr rd;
        rvIsaPkg::Word    data;
        logic             writeEn;
    } Writeback;

endpackage

`default_nettype wire

// ==== hw/rvIsaPkg.sv ====
`default_nettype none

`include "rv_params.svh"

package rvIsaPkg;

    typedef logic [`XLEN-1:0] Word;
    typedef logic [`REG_ADDR_W-1:0] RegAddr;

    // Major opcode, instruction bits 6..2
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,
        STORE  = 5'b01000,
        OP_IMM = 5'b00100,
        OP     = 5'b01100,
        LUI    = 5'b01101,
        AUIPC  = 5'b00101,
        BRANCH = 5'b11000,
        JAL    = 5'b11011,
        JALR   = 5'b11001,
        SYSTEM = 5'b11100 // ECALL, EBREAK and CSR access
    } OpCode;

    typedef enum logic [2:0] {
        ADD_SUB = 3'b000, // funct7[5] selects SUB on OP
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SRLA    = 3'b101, // funct7[5] selects SRA
        OR      = 3'b110,
        AND     = 3'b111
    } AluFunct3;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } BranchFunct3;

    // Low two bits of funct3 on loads and stores
    typedef enum logic [1:0] {
        BITS8  = 2'b00,
        BITS16 = 2'b01,
        BITS32 = 2'b10,
        ERRVAL = 2'b11
    } MemWidth;

    typedef struct packed {
        logic [6:0] funct7;
        RegAddr     rs2;
        RegAddr     rs1;
        logic [2:0] funct3;
        RegAddr     rd;
        OpCode      opCode;
        logic [1:0] lowBits; // 2'b11 for every 32-bit encoding
    } Instruction;

endpackage

`default_nettype wire

// ==== hw/rv_params.svh ====
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Base integer ISA widths
`define XLEN 32
`define REG_ADDR_W 5

`define RESET_PC 32'h0000_1000 // First fetch address after reset

`endif
